// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= TEST PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only when the pass line shows up in the output.
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== include/rv_consts.svh ====
// Core constants for the RV32I subset: widths, reset pc and encodings.
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN 32
`define RESET_PC 32'h0000_0000

// major opcodes.
`define OP_LUI    7'b0110111
`define OP_JAL    7'b1101111
`define OP_BRANCH 7'b1100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011

// funct3 codes.
`define F3_ADD 3'b000
`define F3_SLT 3'b010
`define F3_XOR 3'b100
`define F3_OR  3'b110
`define F3_AND 3'b111
`define F3_BEQ 3'b000
`define F3_BNE 3'b001
`define F3_LW  3'b010
`define F3_SW  3'b010

// funct7 codes.
`define F7_BASE 7'b0000000
`define F7_SUB  7'b0100000

`endif

// ==== rv_core.f ====
+incdir+include
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core.sv
tb/rv_mem_model.sv
tb/rv_core_tb.sv

// ==== tb/rv_core_tb.sv ====
// Testbench for the core with a reference instruction model and retire checker.
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core_tb;

  localparam int CLK_PERIOD      = 100;
  localparam int DRIVE_DELAY     = 5;
  localparam int RESET_CYCLES    = 8;
  localparam int NUM_RETIRE      = 2000;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_RETIRE * 40;

  logic             clk;
  logic             rst;
  rv_pkg::mem_req_t fetch_req;
  logic             fetch_req_valid;
  logic             fetch_req_ready;
  logic             fetch_rsp_valid;
  logic [`XLEN-1:0] fetch_rsp_rdata;
  rv_pkg::mem_req_t data_req;
  logic             data_req_valid;
  logic             data_req_ready;
  logic             data_rsp_valid;
  logic [`XLEN-1:0] data_rsp_rdata;
  logic             retire_valid;
  rv_pkg::retire_t  retire;
  logic             bus_error;

  // reference model state.
  logic [31:0]      model_pc;
  logic [31:0]      model_regs [0:31];
  logic [31:0]      model_dmem [0:63];
  int               retired;

  rv_core rv_core_i (
    .clk(clk),
    .rst(rst),
    .fetch_req(fetch_req),
    .fetch_req_valid(fetch_req_valid),
    .fetch_req_ready(fetch_req_ready),
    .fetch_rsp_valid(fetch_rsp_valid),
    .fetch_rsp_rdata(fetch_rsp_rdata),
    .data_req(data_req),
    .data_req_valid(data_req_valid),
    .data_req_ready(data_req_ready),
    .data_rsp_valid(data_rsp_valid),
    .data_rsp_rdata(data_rsp_rdata),
    .retire_valid(retire_valid),
    .retire(retire)
  );

  rv_mem_model mem_model_i (
    .clk(clk),
    .rst(rst),
    .fetch_req(fetch_req),
    .fetch_req_valid(fetch_req_valid),
    .fetch_req_ready(fetch_req_ready),
    .fetch_rsp_valid(fetch_rsp_valid),
    .fetch_rsp_rdata(fetch_rsp_rdata),
    .data_req(data_req),
    .data_req_valid(data_req_valid),
    .data_req_ready(data_req_ready),
    .data_rsp_valid(data_rsp_valid),
    .data_rsp_rdata(data_rsp_rdata),
    .bus_error(bus_error)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s at retirement %0d: expected 0x%08h, actual 0x%08h",
               name, retired, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // ------------------------------------------------------------
  // reference model stepping the word at model_pc against the retire port.
  // ------------------------------------------------------------
  task automatic check_retirement();
    logic [31:0] w, a, b, val, nxt, addr;
    logic [31:0] imm_i, imm_s, imm_b, imm_j;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        wr, ill, wen;
    w     = mem_model_i.instr_at(model_pc);
    rd    = w[11:7];
    f3    = w[14:12];
    f7    = w[31:25];
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    wr    = 1'b0;
    ill   = 1'b0;
    val   = 32'd0;
    nxt   = model_pc + 32'd4;
    case (w[6:0])
      `OP_LUI: begin
        wr  = 1'b1;
        val = {w[31:12], 12'd0};
      end
      `OP_JAL: begin
        wr  = 1'b1;
        val = model_pc + 32'd4;
        nxt = model_pc + imm_j;
      end
      `OP_BRANCH: begin
        if (f3 != `F3_BEQ && f3 != `F3_BNE) begin
          ill = 1'b1;
        end else if ((a == b) != (f3 == `F3_BNE)) begin
          nxt = model_pc + imm_b;
        end
      end
      `OP_IMM: begin
        ill = (f3 != `F3_ADD);
        wr  = !ill;
        val = a + imm_i;
      end
      `OP_REG: begin
        case ({f7, f3})
          {`F7_BASE, `F3_ADD}: val = a + b;
          {`F7_SUB,  `F3_ADD}: val = a - b;
          {`F7_BASE, `F3_AND}: val = a & b;
          {`F7_BASE, `F3_OR}:  val = a | b;
          {`F7_BASE, `F3_XOR}: val = a ^ b;
          {`F7_BASE, `F3_SLT}: val = {31'd0, $signed(a) < $signed(b)};
          default:             ill = 1'b1;
        endcase
        wr = !ill;
      end
      `OP_LOAD: begin
        ill  = (f3 != `F3_LW);
        wr   = !ill;
        addr = a + imm_i;
        val  = model_dmem[addr[7:2]];
      end
      `OP_STORE: begin
        ill  = (f3 != `F3_SW);
        addr = a + imm_s;
        if (!ill) begin
          model_dmem[addr[7:2]] = b;
        end
      end
      default: ill = 1'b1;
    endcase
    wen = wr && rd != 5'd0 && !ill;
    check_value("retire pc", model_pc, retire.pc);
    check_value("retire rd", {27'd0, rd}, {27'd0, retire.rd});
    check_value("retire wdata", wen ? val : 32'd0, retire.wdata);
    check_value("retire wen", {31'd0, wen}, {31'd0, retire.wen});
    check_value("retire illegal", {31'd0, ill}, {31'd0, retire.illegal});
    if (wen) begin
      model_regs[rd] = val;
    end
    model_pc = nxt;
  endtask

  initial begin
    rst      = 1'b1;
    retired  = 0;
    model_pc = `RESET_PC;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'd0;
    end
    for (int i = 0; i < 64; i++) begin
      model_dmem[i] = mem_model_i.fill_word(i);
    end
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #DRIVE_DELAY;
      check_value("request valid during reset", 32'd0,
                  {29'd0, fetch_req_valid, data_req_valid, retire_valid});
    end
    rst = 1'b0;
    while (retired < NUM_RETIRE) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (retire_valid) begin
        check_retirement();
        retired++;
      end
    end
    $display("TEST PASSED");
    $finish;
  end

  initial begin
    wait (bus_error === 1'b1);
    $display("TEST FAILED");
    $fatal(1, "memory model saw a bad bus request");
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired with %0d of %0d instructions retired", retired, NUM_RETIRE);
    $display("TEST FAILED");
    $fatal(1, "simulation timed out");
  end

endmodule

// ==== tb/rv_mem_model.sv ====
// Bus environment serving a generated program on fetch and a data memory on loads/stores.
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_mem_model (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::mem_req_t fetch_req,
  input  logic             fetch_req_valid,
  output logic             fetch_req_ready,
  output logic             fetch_rsp_valid,
  output logic [`XLEN-1:0] fetch_rsp_rdata,
  input  rv_pkg::mem_req_t data_req,
  input  logic             data_req_valid,
  output logic             data_req_ready,
  output logic             data_rsp_valid,
  output logic [`XLEN-1:0] data_rsp_rdata,
  output logic             bus_error
);

  localparam logic [31:0] SEED        = 32'd29825;
  localparam int          DRIVE_DELAY = 5;

  logic [31:0]      dmem [0:63];
  logic [31:0]      fetch_rng;
  logic [31:0]      data_rng;
  rv_pkg::mem_req_t fetch_held;
  rv_pkg::mem_req_t data_held;
  logic             fetch_error;
  logic             data_error;

  assign bus_error = fetch_error | data_error;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return 32'h5A5A_0000 ^ (idx * 32'h0001_0107);
  endfunction

  // ------------------------------------------------------------
  // program generator as a pure function of the pc.
  // ------------------------------------------------------------
  function automatic logic [31:0] instr_at(input logic [31:0] pc);
    logic [31:0] h, w;
    logic [4:0]  rd, rs1, rs2;
    logic [11:0] imm, mem_off;
    logic [12:0] off;
    h       = xorshift32(xorshift32(pc ^ SEED));
    rd      = {2'b00, h[14:12]};
    rs1     = {2'b00, h[17:15]};
    rs2     = {2'b00, h[20:18]};
    imm     = h[31:20];
    off     = {8'd0, h[10:8], 2'b00} + 13'd4;
    mem_off = {4'd0, h[29:24], 2'b00};
    case (h[3:0])
      4'd0:  w = {h[31:7], 7'b1111111};
      4'd1:  w = {h[31:12], rd, `OP_LUI};
      4'd2:  w = {1'b0, off[10:1], 1'b0, 8'd0, rd, `OP_JAL};
      4'd3:  w = {1'b0, off[10:5], rs2, rs1, `F3_BEQ, off[4:1], 1'b0, `OP_BRANCH};
      4'd4:  w = {1'b0, off[10:5], rs2, rs1, `F3_BNE, off[4:1], 1'b0, `OP_BRANCH};
      4'd5, 4'd6, 4'd7: w = {imm, rs1, `F3_ADD, rd, `OP_IMM};
      4'd13, 4'd15: w = {mem_off, 5'd0, `F3_LW, rd, `OP_LOAD};
      4'd14: w = {mem_off[11:5], rs2, 5'd0, `F3_SW, mem_off[4:0], `OP_STORE};
      default: begin
        case (h[23:21])
          3'd1:    w = {`F7_SUB,  rs2, rs1, `F3_ADD, rd, `OP_REG};
          3'd2:    w = {`F7_BASE, rs2, rs1, `F3_AND, rd, `OP_REG};
          3'd3:    w = {`F7_BASE, rs2, rs1, `F3_OR,  rd, `OP_REG};
          3'd4:    w = {`F7_BASE, rs2, rs1, `F3_XOR, rd, `OP_REG};
          3'd5:    w = {`F7_BASE, rs2, rs1, `F3_SLT, rd, `OP_REG};
          default: w = {`F7_BASE, rs2, rs1, `F3_ADD, rd, `OP_REG};
        endcase
      end
    endcase
    // x1..x7 get a value before anything reads them.
    if (pc < 32'd28) begin
      w = {imm, 5'd0, `F3_ADD, pc[6:2] + 5'd1, `OP_IMM};
    end
    return w;
  endfunction

  // fetch port.
  initial begin
    fetch_req_ready = 1'b0;
    fetch_rsp_valid = 1'b0;
    fetch_rsp_rdata = '0;
    fetch_error     = 1'b0;
    fetch_rng       = SEED;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (fetch_req_valid && !rst) begin
        fetch_held = fetch_req;
        fetch_rng  = xorshift32(fetch_rng);
        if (fetch_held.we !== 1'b0) begin
          $display("fetch request asked for a write instead of a read");
          fetch_error = 1'b1;
        end
        repeat (int'(fetch_rng[1:0])) begin
          @(posedge clk);
          #DRIVE_DELAY;
          if (!fetch_req_valid || fetch_req !== fetch_held) begin
            $display("fetch request changed or dropped while ready was low");
            fetch_error = 1'b1;
          end
        end
        fetch_req_ready = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        fetch_req_ready = 1'b0;
        repeat (int'(fetch_rng[3:2])) begin
          @(posedge clk);
          #DRIVE_DELAY;
        end
        fetch_rsp_rdata = instr_at(fetch_held.addr);
        fetch_rsp_valid = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        fetch_rsp_valid = 1'b0;
      end
    end
  end

  // data port.
  initial begin
    data_req_ready = 1'b0;
    data_rsp_valid = 1'b0;
    data_rsp_rdata = '0;
    data_error     = 1'b0;
    data_rng       = xorshift32(SEED);
    for (int i = 0; i < 64; i++) begin
      dmem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (data_req_valid && !rst) begin
        data_held = data_req;
        data_rng  = xorshift32(data_rng);
        repeat (int'(data_rng[1:0])) begin
          @(posedge clk);
          #DRIVE_DELAY;
          if (!data_req_valid || data_req !== data_held) begin
            $display("data request changed or dropped while ready was low");
            data_error = 1'b1;
          end
        end
        data_req_ready = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        data_req_ready = 1'b0;
        if (data_held.we) begin
          dmem[data_held.addr[7:2]] = data_held.wdata;
        end
        repeat (int'(data_rng[3:2])) begin
          @(posedge clk);
          #DRIVE_DELAY;
        end
        // a store gets a pulse too with zero data.
        data_rsp_rdata = data_held.we ? 32'd0 : dmem[data_held.addr[7:2]];
        data_rsp_valid = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        data_rsp_valid = 1'b0;
      end
    end
  end

endmodule

// ==== verilog/rv_core.sv ====
// Top of the multicycle core joining fetch, decode, execute and result stages.
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core (
  input  logic             clk,
  input  logic             rst,

  // instruction fetch port.
  output rv_pkg::mem_req_t fetch_req,
  output logic             fetch_req_valid,
  input  logic             fetch_req_ready,
  input  logic             fetch_rsp_valid,
  input  logic [`XLEN-1:0] fetch_rsp_rdata,

  // load/store port.
  output rv_pkg::mem_req_t data_req,
  output logic             data_req_valid,
  input  logic             data_req_ready,
  input  logic             data_rsp_valid,
  input  logic [`XLEN-1:0] data_rsp_rdata,

  output logic             retire_valid,
  output rv_pkg::retire_t  retire
);

  logic             instr_valid;
  rv_pkg::instr_u   instr;
  logic [`XLEN-1:0] instr_pc;
  logic             dec_valid;
  rv_pkg::decoded_t dec;
  logic             ex_valid;
  rv_pkg::exec_t    ex;
  logic             rf_wen;
  logic [4:0]       rf_waddr;
  logic [`XLEN-1:0] rf_wdata;
  logic             redirect;
  logic [`XLEN-1:0] redirect_pc;

  rv_fetch rv_fetch_i (
    .clk(clk),
    .rst(rst),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .fetch_req(fetch_req),
    .fetch_req_valid(fetch_req_valid),
    .fetch_req_ready(fetch_req_ready),
    .fetch_rsp_valid(fetch_rsp_valid),
    .fetch_rsp_rdata(fetch_rsp_rdata),
    .instr_valid(instr_valid),
    .instr(instr),
    .instr_pc(instr_pc)
  );

  rv_decode rv_decode_i (
    .clk(clk),
    .rst(rst),
    .instr_valid(instr_valid),
    .instr(instr),
    .instr_pc(instr_pc),
    .rf_wen(rf_wen),
    .rf_waddr(rf_waddr),
    .rf_wdata(rf_wdata),
    .dec_valid(dec_valid),
    .dec(dec)
  );

  rv_execute rv_execute_i (
    .clk(clk),
    .rst(rst),
    .dec_valid(dec_valid),
    .dec(dec),
    .ex_valid(ex_valid),
    .ex(ex)
  );

  rv_result rv_result_i (
    .clk(clk),
    .rst(rst),
    .ex_valid(ex_valid),
    .ex(ex),
    .data_req(data_req),
    .data_req_valid(data_req_valid),
    .data_req_ready(data_req_ready),
    .data_rsp_valid(data_rsp_valid),
    .data_rsp_rdata(data_rsp_rdata),
    .rf_wen(rf_wen),
    .rf_waddr(rf_waddr),
    .rf_wdata(rf_wdata),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .retire_valid(retire_valid),
    .retire(retire)
  );

endmodule

// ==== verilog/rv_decode.sv ====
// Decode stage with register file reads and immediate generation.
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_decode (
  input  logic             clk,
  input  logic             rst,
  input  logic             instr_valid,
  input  rv_pkg::instr_u   instr,
  input  logic [`XLEN-1:0] instr_pc,
  input  logic             rf_wen,
  input  logic [4:0]       rf_waddr,
  input  logic [`XLEN-1:0] rf_wdata,
  output logic             dec_valid,
  output rv_pkg::decoded_t dec
);

  logic [`XLEN-1:0] regs [1:31];
  logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [4:0]       rs1, rs2;
  logic [6:0]       opcode, funct7;
  logic [2:0]       funct3;
  rv_pkg::decoded_t d;

  // ------------------------------------------------------------
  // register file without a storage word for x0.
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rf_wen && rf_waddr != 5'd0) begin
      regs[rf_waddr] <= rf_wdata;
    end
  end

  assign opcode = instr.r_fmt.opcode;
  assign funct3 = instr.r_fmt.funct3;
  assign funct7 = instr.r_fmt.funct7;
  assign rs1    = instr.r_fmt.rs1;
  assign rs2    = instr.r_fmt.rs2;

  assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
  assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
  assign imm_b = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                  instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
  assign imm_u = {instr.u_fmt.imm, 12'b0};
  assign imm_j = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                  instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};

  always_comb begin
    d         = '0;
    d.pc      = instr_pc;
    d.rd      = instr.r_fmt.rd;
    d.rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    d.rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];
    d.alu_op  = rv_pkg::ALU_ADD;
    d.illegal = 1'b1;
    case (opcode)
      `OP_LUI: begin
        d.imm       = imm_u;
        d.alu_op    = rv_pkg::ALU_PASS_B;
        d.use_imm   = 1'b1;
        d.writes_rd = 1'b1;
        d.illegal   = 1'b0;
      end
      `OP_JAL: begin
        d.imm = imm_j;
        {d.is_jal, d.writes_rd, d.illegal} = 3'b110;
      end
      `OP_BRANCH: if (funct3 == `F3_BEQ || funct3 == `F3_BNE) begin
        d.imm = imm_b;
        {d.is_branch, d.branch_ne, d.illegal} = {1'b1, funct3 == `F3_BNE, 1'b0};
      end
      `OP_IMM: if (funct3 == `F3_ADD) begin
        {d.imm, d.use_imm, d.writes_rd, d.illegal} = {imm_i, 3'b110};
      end
      `OP_LOAD: if (funct3 == `F3_LW) begin
        {d.imm, d.use_imm, d.is_load, d.writes_rd, d.illegal} = {imm_i, 4'b1110};
      end
      `OP_STORE: if (funct3 == `F3_SW) begin
        {d.imm, d.use_imm, d.is_store, d.illegal} = {imm_s, 3'b110};
      end
      `OP_REG: begin
        {d.writes_rd, d.illegal} = 2'b10;
        case ({funct7, funct3})
          {`F7_BASE, `F3_ADD}: d.alu_op = rv_pkg::ALU_ADD;
          {`F7_SUB,  `F3_ADD}: d.alu_op = rv_pkg::ALU_SUB;
          {`F7_BASE, `F3_AND}: d.alu_op = rv_pkg::ALU_AND;
          {`F7_BASE, `F3_OR}:  d.alu_op = rv_pkg::ALU_OR;
          {`F7_BASE, `F3_XOR}: d.alu_op = rv_pkg::ALU_XOR;
          {`F7_BASE, `F3_SLT}: d.alu_op = rv_pkg::ALU_SLT;
          default: {d.writes_rd, d.illegal} = 2'b01;
        endcase
      end
      default: d.illegal = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      dec <= d;
    end
  end

  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    rf_wen |-> rf_waddr != 5'd0)
    else $error("register write aimed at x0");

endmodule

// ==== verilog/rv_execute.sv ====
// Execute stage computing the ALU result, branch outcome and next pc.
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_execute (
  input  logic             clk,
  input  logic             rst,
  input  logic             dec_valid,
  input  rv_pkg::decoded_t dec,
  output logic             ex_valid,
  output rv_pkg::exec_t    ex
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] pc_target;
  logic             taken;
  rv_pkg::exec_t    e;

  assign op_a = dec.rs1_val;
  assign op_b = dec.use_imm ? dec.imm : dec.rs2_val;

  // loads and stores arrive with ALU_ADD for the address.
  always_comb begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD:    alu_out = op_a + op_b;
      rv_pkg::ALU_SUB:    alu_out = op_a - op_b;
      rv_pkg::ALU_AND:    alu_out = op_a & op_b;
      rv_pkg::ALU_OR:     alu_out = op_a | op_b;
      rv_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
      rv_pkg::ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_PASS_B: alu_out = op_b;
      default:            alu_out = op_a + op_b;
    endcase
  end

  // ------------------------------------------------------------
  // control flow.
  // ------------------------------------------------------------
  assign pc_plus4  = dec.pc + `XLEN'd4;
  assign pc_target = dec.pc + dec.imm;
  assign taken     = dec.is_branch && ((dec.rs1_val == dec.rs2_val) ^ dec.branch_ne);

  always_comb begin
    e            = '0;
    e.pc         = dec.pc;
    e.next_pc    = (taken || dec.is_jal) ? pc_target : pc_plus4;
    e.result     = dec.is_jal ? pc_plus4 : alu_out;
    e.store_data = dec.rs2_val;
    e.rd         = dec.rd;
    e.is_load    = dec.is_load;
    e.is_store   = dec.is_store;
    e.writes_rd  = dec.writes_rd;
    e.illegal    = dec.illegal;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      ex <= e;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    ex_valid |-> ex.next_pc[1:0] == 2'b00)
    else $error("next pc is not word aligned");

endmodule

// ==== verilog/rv_fetch.sv ====
// Fetch unit holding the pc and issuing one instruction request at a time.
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_fetch (
  input  logic             clk,
  input  logic             rst,
  input  logic             redirect,
  input  logic [`XLEN-1:0] redirect_pc,
  output rv_pkg::mem_req_t fetch_req,
  output logic             fetch_req_valid,
  input  logic             fetch_req_ready,
  input  logic             fetch_rsp_valid,
  input  logic [`XLEN-1:0] fetch_rsp_rdata,
  output logic             instr_valid,
  output rv_pkg::instr_u   instr,
  output logic [`XLEN-1:0] instr_pc
);

  typedef enum logic [1:0] {S_REQ, S_RSP, S_REDIR} state_e;

  state_e           state;
  logic [`XLEN-1:0] pc;

  // fetches are read only.
  assign fetch_req = '{addr: pc, we: 1'b0, wdata: {`XLEN{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= S_REQ;
      pc              <= `RESET_PC;
      fetch_req_valid <= 1'b0;
      instr_valid     <= 1'b0;
    end else begin
      instr_valid <= 1'b0;
      case (state)
        S_REQ: begin
          // first request after reset is raised here.
          if (!fetch_req_valid) begin
            fetch_req_valid <= 1'b1;
          end else if (fetch_req_ready) begin
            fetch_req_valid <= 1'b0;
            state           <= S_RSP;
          end
        end
        S_RSP: begin
          if (fetch_rsp_valid) begin
            instr_valid <= 1'b1;
            state       <= S_REDIR;
          end
        end
        S_REDIR: begin
          if (redirect) begin
            pc              <= redirect_pc;
            fetch_req_valid <= 1'b1;
            state           <= S_REQ;
          end
        end
        default: state <= S_REQ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_RSP && fetch_rsp_valid) begin
      instr    <= fetch_rsp_rdata;
      instr_pc <= pc;
    end
  end

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    fetch_req_valid && !fetch_req_ready |=> fetch_req_valid && $stable(fetch_req))
    else $error("fetch request changed while stalled");

endmodule

// ==== verilog/rv_pkg.sv ====
// Shared types of the core: instruction formats, bus request and stage records.
`include "rv_consts.svh"

package rv_pkg;

  // ------------------------------------------------------------
  // instruction word views.
  // ------------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  // ------------------------------------------------------------
  // bus and stage records.
  // ------------------------------------------------------------
  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic             we;
    logic [`XLEN-1:0] wdata;
  } mem_req_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] imm;
    logic [4:0]       rd;
    alu_op_e          alu_op;
    logic             use_imm;
    logic             is_load;
    logic             is_store;
    logic             is_branch;
    logic             branch_ne;
    logic             is_jal;
    logic             writes_rd;
    logic             illegal;
  } decoded_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] store_data;
    logic [4:0]       rd;
    logic             is_load;
    logic             is_store;
    logic             writes_rd;
    logic             illegal;
  } exec_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [4:0]       rd;
    logic [`XLEN-1:0] wdata;
    logic             wen;
    logic             illegal;
  } retire_t;

endpackage

// ==== verilog/rv_result.sv ====
// Result stage sequencing data accesses, write-back and retirement.
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_result (
  input  logic             clk,
  input  logic             rst,
  input  logic             ex_valid,
  input  rv_pkg::exec_t    ex,
  output rv_pkg::mem_req_t data_req,
  output logic             data_req_valid,
  input  logic             data_req_ready,
  input  logic             data_rsp_valid,
  input  logic [`XLEN-1:0] data_rsp_rdata,
  output logic             rf_wen,
  output logic [4:0]       rf_waddr,
  output logic [`XLEN-1:0] rf_wdata,
  output logic             redirect,
  output logic [`XLEN-1:0] redirect_pc,
  output logic             retire_valid,
  output rv_pkg::retire_t  retire
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_RSP} state_e;

  state_e           state;
  rv_pkg::exec_t    ex_q;
  logic [`XLEN-1:0] wb_data;
  logic             done;
  logic             wb_en;

  assign data_req = '{addr: ex_q.result, we: ex_q.is_store, wdata: ex_q.store_data};

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= S_IDLE;
      data_req_valid <= 1'b0;
      done           <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (ex_valid && (ex.is_load || ex.is_store)) begin
            data_req_valid <= 1'b1;
            state          <= S_REQ;
          end else if (ex_valid) begin
            done <= 1'b1;
          end
        end
        S_REQ: begin
          if (data_req_ready) begin
            data_req_valid <= 1'b0;
            state          <= S_RSP;
          end
        end
        S_RSP: begin
          // stores complete on the same pulse, data ignored.
          if (data_rsp_valid) begin
            done  <= 1'b1;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      ex_q    <= ex;
      wb_data <= ex.result;
    end else if (state == S_RSP && data_rsp_valid && ex_q.is_load) begin
      wb_data <= data_rsp_rdata;
    end
  end

  // ------------------------------------------------------------
  // write-back and retire.
  // ------------------------------------------------------------
  assign wb_en        = ex_q.writes_rd && ex_q.rd != 5'd0 && !ex_q.illegal;
  assign rf_wen       = done && wb_en;
  assign rf_waddr     = ex_q.rd;
  assign rf_wdata     = wb_data;
  assign redirect     = done;
  assign redirect_pc  = ex_q.next_pc;
  assign retire_valid = done;
  assign retire       = '{pc: ex_q.pc, rd: ex_q.rd, wdata: wb_en ? wb_data : {`XLEN{1'b0}},
                          wen: wb_en, illegal: ex_q.illegal};

  a_one_access: assert property (@(posedge clk) disable iff (rst)
    !(data_req_valid && data_rsp_valid))
    else $error("data response while a request is pending");

endmodule
